// ==== Bender.yml ====
package:
  name: l2_cache_ctrl

sources:
  - source/l2_ctrl_pkg.sv
  - source/l2_req_arbiter.sv
  - source/l2_tag_compare.sv
  - source/l2_victim_select.sv
  - source/l2_word_select.sv
  - source/l2_ctrl_fsm.sv
  - source/l2_cache_ctrl.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/l2_ctrl_checker.sv
      - tests/tb_l2_cache_ctrl.sv

// ==== sim.f ====
+incdir+tests
source/l2_ctrl_pkg.sv
source/l2_req_arbiter.sv
source/l2_tag_compare.sv
source/l2_victim_select.sv
source/l2_word_select.sv
source/l2_ctrl_fsm.sv
source/l2_cache_ctrl.sv
tests/l2_ctrl_checker.sv
tests/tb_l2_cache_ctrl.sv

// ==== source/l2_cache_ctrl.sv ====
`timescale 1ns/1ns

module l2_cache_ctrl
    import l2_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    // L1 side
    input  l1_req_t                   ic_req,
    input  l1_req_t                   dc_req,
    input  logic                      l1_done,
    output logic                      ic_en,
    output logic                      dc_en,
    output word_t                     data_wd_l2,
    output logic                      data_wd_l2_en,
    output logic                      mem_wr_ic_en,
    output logic                      mem_wr_dc_en,
    // tag, data and dirty arrays
    output index_t                    index,
    output offset_t                   offset,
    output tag_entry_t                tag_wd,
    output way_mask_t                 block_re,
    output way_mask_t                 block_we,
    output logic                      dirty_wd,
    output logic                      wd_from_l1_en,
    output logic                      wd_from_mem_en,
    input  logic                      l2_complete_r,
    input  logic                      l2_complete_w,
    input  tag_entry_t [NUM_WAYS-1:0] tag_rd,
    input  line_t [NUM_WAYS-1:0]      data_rd,
    input  way_mask_t                 dirty_rd,
    input  plru_t                     plru,
    // main memory
    output logic                      mem_re,
    output logic                      mem_we,
    output mem_addr_t                 mem_addr,
    output line_t                     mem_wd,
    input  line_t                     mem_rd,
    input  logic                      mem_complete_r,
    input  logic                      mem_complete_w
);

    l1_req_t held_req;
    logic    grab;
    logic    release_req;
    logic    hit;
    way_t    hit_way;
    way_t    victim_way;
    logic    victim_dirty;
    tag_t    victim_tag;
    logic    from_mem;
    way_t    word_way;
    way_t    mem_line_sel_way;

    //////////////////////////////////////////////////////////////////////
    // address fields toward the arrays
    //////////////////////////////////////////////////////////////////////

    assign index  = held_req.addr.index;
    assign offset = held_req.addr.offset;
    assign tag_wd = '{valid: 1'b1, tag: held_req.addr.tag};
    assign mem_wd = data_rd[mem_line_sel_way];    // victim line for write-back

    l2_req_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .ic_req      (ic_req),
        .dc_req      (dc_req),
        .grab        (grab),
        .release_req (release_req),
        .req         (held_req),
        .ic_en       (ic_en),
        .dc_en       (dc_en)
    );

    l2_tag_compare u_tag_compare (
        .tag_rd  (tag_rd),
        .tag     (held_req.addr.tag),
        .hit     (hit),
        .hit_way (hit_way)
    );

    l2_victim_select u_victim_select (
        .tag_rd       (tag_rd),
        .dirty_rd     (dirty_rd),
        .plru         (plru),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    l2_word_select u_word_select (
        .data_rd  (data_rd),
        .mem_rd   (mem_rd),
        .from_mem (from_mem),
        .way      (word_way),
        .offset   (held_req.addr.offset),
        .word     (data_wd_l2)
    );

    l2_ctrl_fsm u_fsm (
        .clk              (clk),
        .rst              (rst),
        .req              (held_req),
        .ic_en            (ic_en),
        .dc_en            (dc_en),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .victim_dirty     (victim_dirty),
        .victim_tag       (victim_tag),
        .l1_done          (l1_done),
        .l2_complete_r    (l2_complete_r),
        .l2_complete_w    (l2_complete_w),
        .mem_complete_r   (mem_complete_r),
        .mem_complete_w   (mem_complete_w),
        .grab             (grab),
        .release_req      (release_req),
        .block_re         (block_re),
        .block_we         (block_we),
        .dirty_wd         (dirty_wd),
        .wd_from_l1_en    (wd_from_l1_en),
        .wd_from_mem_en   (wd_from_mem_en),
        .from_mem         (from_mem),
        .word_way         (word_way),
        .mem_re           (mem_re),
        .mem_we           (mem_we),
        .mem_addr         (mem_addr),
        .mem_line_sel_way (mem_line_sel_way),
        .data_wd_l2_en    (data_wd_l2_en),
        .mem_wr_ic_en     (mem_wr_ic_en),
        .mem_wr_dc_en     (mem_wr_dc_en)
    );

endmodule

// ==== source/l2_ctrl_fsm.sv ====
`timescale 1ns/1ns

module l2_ctrl_fsm
    import l2_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  l1_req_t   req,
    input  logic      ic_en,
    input  logic      dc_en,
    input  logic      hit,
    input  way_t      hit_way,
    input  way_t      victim_way,
    input  logic      victim_dirty,
    input  tag_t      victim_tag,
    input  logic      l1_done,
    input  logic      l2_complete_r,
    input  logic      l2_complete_w,
    input  logic      mem_complete_r,
    input  logic      mem_complete_w,
    output logic      grab,
    output logic      release_req,
    output way_mask_t block_re,
    output way_mask_t block_we,
    output logic      dirty_wd,
    output logic      wd_from_l1_en,
    output logic      wd_from_mem_en,
    output logic      from_mem,
    output way_t      word_way,
    output logic      mem_re,
    output logic      mem_we,
    output mem_addr_t mem_addr,
    output way_t      mem_line_sel_way,
    output logic      data_wd_l2_en,
    output logic      mem_wr_ic_en,
    output logic      mem_wr_dc_en
);

    l2_state_e state;
    l2_state_e state_next;
    logic      wb_line;     // victim went back to memory first
    mem_addr_t req_line;

    function automatic way_mask_t way_onehot(input way_t way);
        way_onehot = way_mask_t'(1) << way;
    endfunction

    assign req_line    = '{tag: req.addr.tag, index: req.addr.index};
    assign grab        = (state == idle);
    assign release_req = (state != idle) && (state_next == idle);  // grant ends with the state

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            idle:      if (req.req) state_next = access;
            access: begin
                if (l2_complete_r) begin
                    if (hit) begin
                        state_next = req.write ? write_hit : write_l1;
                    end else begin
                        state_next = victim_dirty ? write_mem : read_mem;
                    end
                end
            end
            write_l1:  if (l1_done) state_next = idle;
            write_hit: if (l2_complete_w) state_next = idle;
            write_mem: if (mem_complete_w) state_next = read_mem;
            read_mem: begin
                if (mem_complete_r) begin
                    if (req.write) begin
                        state_next = fill_dirty_w;
                    end else begin
                        state_next = wb_line ? fill_dirty_r : fill_clean;
                    end
                end
            end
            fill_clean, fill_dirty_r: if (l2_complete_w) state_next = idle;
            fill_dirty_w:             if (l2_complete_w) state_next = write_hit;
            default:   state_next = idle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // registered outputs
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= idle;
            block_re       <= '0;
            block_we       <= '0;
            dirty_wd       <= 1'b0;
            wd_from_l1_en  <= 1'b0;
            wd_from_mem_en <= 1'b0;
            mem_re         <= 1'b0;
            mem_we         <= 1'b0;
            data_wd_l2_en  <= 1'b0;
            mem_wr_ic_en   <= 1'b0;
            mem_wr_dc_en   <= 1'b0;
        end else begin
            state <= state_next;
            case (state)
                idle: begin
                    if (req.req) block_re <= '1;    // read all four ways
                end
                access: begin
                    if (l2_complete_r) begin
                        block_re         <= '0;
                        mem_line_sel_way <= victim_way;
                        wb_line          <= victim_dirty;
                        if (hit && !req.write) begin
                            data_wd_l2_en <= 1'b1;
                            from_mem      <= 1'b0;
                            word_way      <= hit_way;
                        end else if (hit) begin
                            block_we      <= way_onehot(hit_way);
                            dirty_wd      <= 1'b1;
                            wd_from_l1_en <= 1'b1;
                        end else if (victim_dirty) begin
                            mem_we   <= 1'b1;    // write-back of the victim line
                            mem_addr <= '{tag: victim_tag, index: req.addr.index};
                        end else begin
                            mem_re   <= 1'b1;
                            mem_addr <= req_line;
                        end
                    end
                end
                write_l1: begin
                    if (l1_done) data_wd_l2_en <= 1'b0;
                end
                write_hit: begin
                    if (l2_complete_w) begin
                        block_we      <= '0;
                        dirty_wd      <= 1'b0;
                        wd_from_l1_en <= 1'b0;
                    end
                end
                write_mem: begin
                    if (mem_complete_w) begin
                        mem_we   <= 1'b0;
                        mem_re   <= 1'b1;
                        mem_addr <= req_line;
                    end
                end
                read_mem: begin
                    if (mem_complete_r) begin
                        mem_re         <= 1'b0;
                        block_we       <= way_onehot(mem_line_sel_way);
                        wd_from_mem_en <= 1'b1;
                        dirty_wd       <= 1'b0;
                        if (!req.write) begin    // L1 only takes the word on reads
                            data_wd_l2_en <= 1'b1;
                            from_mem      <= 1'b1;
                            mem_wr_ic_en  <= ic_en;
                            mem_wr_dc_en  <= dc_en;
                        end
                    end
                end
                fill_clean, fill_dirty_r: begin
                    if (l2_complete_w) begin
                        block_we       <= '0;
                        wd_from_mem_en <= 1'b0;
                        data_wd_l2_en  <= 1'b0;
                        mem_wr_ic_en   <= 1'b0;
                        mem_wr_dc_en   <= 1'b0;
                    end
                end
                fill_dirty_w: begin
                    if (l2_complete_w) begin
                        // refilled way now takes the L1 line
                        block_we       <= way_onehot(mem_line_sel_way);
                        wd_from_mem_en <= 1'b0;
                        dirty_wd       <= 1'b1;
                        wd_from_l1_en  <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== source/l2_ctrl_pkg.sv ====
package l2_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // geometry, fixed by the 3-bit replacement tree
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_WAYS       = 4;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [16:0]  tag_t;
    typedef logic [8:0]   index_t;
    typedef logic [1:0]   offset_t;    // word within line
    typedef logic [1:0]   way_t;
    typedef logic [2:0]   plru_t;      // tree bits, bit 0 is the root
    typedef logic [127:0] word_t;      // one L1 word
    typedef logic [511:0] line_t;      // word 0 in the low bits
    typedef logic [NUM_WAYS-1:0] way_mask_t;

    // 28-bit L2 request address
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } l2_addr_t;

    // memory works on whole lines
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } mem_addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic     req;     // held by L1 until served
        logic     write;   // L1 writes a line back
        l2_addr_t addr;
    } l1_req_t;

    //////////////////////////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        idle,
        access,
        write_l1,
        write_hit,
        write_mem,
        read_mem,
        fill_clean,
        fill_dirty_r,
        fill_dirty_w
    } l2_state_e;

endpackage

// ==== source/l2_req_arbiter.sv ====
`timescale 1ns/1ns

module l2_req_arbiter
    import l2_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  l1_req_t ic_req,
    input  l1_req_t dc_req,
    input  logic    grab,
    input  logic    release_req,
    output l1_req_t req,
    output logic    ic_en,
    output logic    dc_en
);

    l1_req_t held;
    l1_req_t winner;

    // instruction side has priority
    assign winner = ic_req.req ? ic_req : dc_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            ic_en <= 1'b0;
            dc_en <= 1'b0;
        end else if (release_req) begin
            ic_en <= 1'b0;
            dc_en <= 1'b0;
        end else if (grab) begin
            ic_en <= ic_req.req;
            dc_en <= !ic_req.req && dc_req.req;
        end
    end

    always_ff @(posedge clk) begin
        if (grab) begin
            held <= winner;    // frozen once the FSM leaves idle
        end
    end

    // before a grant the FSM sees the live winner, afterwards the held copy
    assign req = (ic_en || dc_en) ? held : winner;

endmodule

// ==== source/l2_tag_compare.sv ====
`timescale 1ns/1ns

module l2_tag_compare
    import l2_ctrl_pkg::*;
(
    input  tag_entry_t [NUM_WAYS-1:0] tag_rd,
    input  tag_t                      tag,
    output logic                      hit,
    output way_t                      hit_way
);

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        // walk down so the lowest matching way is the last one written
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (tag_rd[i].valid && (tag_rd[i].tag == tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(i);
            end
        end
    end

endmodule

// ==== source/l2_victim_select.sv ====
`timescale 1ns/1ns

module l2_victim_select
    import l2_ctrl_pkg::*;
(
    input  tag_entry_t [NUM_WAYS-1:0] tag_rd,
    input  way_mask_t                 dirty_rd,
    input  plru_t                     plru,
    output way_t                      victim_way,
    output logic                      victim_dirty,
    output tag_t                      victim_tag
);

    logic all_valid;
    way_t free_way;

    always_comb begin
        all_valid = 1'b1;
        free_way  = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (!tag_rd[i].valid) begin
                all_valid = 1'b0;
                free_way  = way_t'(i);    // lowest invalid wins
            end
        end
    end

    always_comb begin
        if (!all_valid) begin
            victim_way = free_way;
        end else if (!plru[0]) begin
            victim_way = plru[1] ? way_t'(1) : way_t'(0);    // left pair
        end else begin
            victim_way = plru[2] ? way_t'(3) : way_t'(2);    // right pair
        end
    end

    // an invalid way never needs a write-back
    assign victim_dirty = tag_rd[victim_way].valid && dirty_rd[victim_way];
    assign victim_tag   = tag_rd[victim_way].tag;

endmodule

// ==== source/l2_word_select.sv ====
`timescale 1ns/1ns

module l2_word_select
    import l2_ctrl_pkg::*;
(
    input  line_t [NUM_WAYS-1:0] data_rd,
    input  line_t                mem_rd,
    input  logic                 from_mem,
    input  way_t                 way,
    input  offset_t              offset,
    output word_t                word
);

    line_t                       sel_line;
    word_t [WORDS_PER_LINE-1:0]  words;

    assign sel_line = from_mem ? mem_rd : data_rd[way];   // refill or hit line
    assign words    = sel_line;                           // word 0 is the low 128 bits
    assign word     = words[offset];

endmodule

// ==== tests/l2_tb_defs.svh ====
`ifndef L2_TB_DEFS_SVH
`define L2_TB_DEFS_SVH

// one golden line, see the column notes at the top of the data file
typedef struct packed {
    logic [1:0]                             src;     // 0 ic, 1 dc, 2 both
    logic                                   wr;
    l2_ctrl_pkg::l2_addr_t                  addr;
    l2_ctrl_pkg::tag_entry_t [3:0]          tags;
    l2_ctrl_pkg::way_mask_t                 dirty;
    l2_ctrl_pkg::plru_t                     plru;
    logic [1:0]                             kind;    // 0 rd hit .. 3 dirty miss
    l2_ctrl_pkg::way_t                      way;
    l2_ctrl_pkg::mem_addr_t                 wb;
} tvec_t;

// array word pattern, built from way, word and index
function automatic l2_ctrl_pkg::word_t way_word(input int w, input int k,
                                               input l2_ctrl_pkg::index_t idx);
    way_word = {4{6'h2a, l2_ctrl_pkg::way_t'(w), l2_ctrl_pkg::offset_t'(k), 13'h0, idx}};
endfunction

// memory word pattern, covers the whole line address
function automatic l2_ctrl_pkg::word_t mem_word(input l2_ctrl_pkg::mem_addr_t a,
                                               input int k);
    mem_word = {4{4'hc, l2_ctrl_pkg::offset_t'(k), a}};
endfunction

function automatic l2_ctrl_pkg::line_t way_line(input int w, input l2_ctrl_pkg::index_t idx);
    l2_ctrl_pkg::line_t line;
    for (int k = 0; k < 4; k++) begin
        line[k*128 +: 128] = way_word(w, k, idx);
    end
    way_line = line;
endfunction

function automatic l2_ctrl_pkg::line_t mem_line(input l2_ctrl_pkg::mem_addr_t a);
    l2_ctrl_pkg::line_t line;
    for (int k = 0; k < 4; k++) begin
        line[k*128 +: 128] = mem_word(a, k);
    end
    mem_line = line;
endfunction

`endif

// ==== tests/l2_ctrl_checker.sv ====
`timescale 1ns/1ns
`include "l2_tb_defs.svh"

module l2_ctrl_checker
    import l2_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  tvec_t     exp,
    input  logic      exp_ic,       // instruction side should own this grant
    input  logic      ic_en,
    input  logic      dc_en,
    input  word_t     data_wd_l2,
    input  logic      data_wd_l2_en,
    input  logic      mem_wr_ic_en,
    input  logic      mem_wr_dc_en,
    input  index_t    index,
    input  offset_t   offset,
    input  tag_entry_t tag_wd,
    input  way_mask_t block_re,
    input  way_mask_t block_we,
    input  logic      dirty_wd,
    input  logic      wd_from_l1_en,
    input  logic      wd_from_mem_en,
    input  logic      mem_re,
    input  logic      mem_we,
    input  mem_addr_t mem_addr,
    input  line_t     mem_wd,
    output int        tests,
    output int        failures
);

    logic busy;
    logic saw_re, saw_we, saw_fill, saw_l1w, saw_rd;
    logic idle_flagged;
    int   errs;

    task automatic check_val(input string name, input logic [511:0] got,
                             input logic [511:0] want);
        if (got !== want) begin
            $display("error %s got %0h exp %0h", name, got, want);
            errs++;
        end
    endtask

    task automatic complain(input string what);
        $display("test %0d: %s", tests + 1, what);
        errs++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // per-cycle comparison while a grant is held
    //////////////////////////////////////////////////////////////////////

    task automatic sample();
        logic      miss;
        mem_addr_t line_addr;
        miss      = exp.kind[1];
        line_addr = '{tag: exp.addr.tag, index: exp.addr.index};
        if (ic_en && dc_en) complain("both grants high at once");
        if (mem_we && !saw_we) begin
            saw_we = 1'b1;
            check_val("mem_addr", mem_addr, exp.wb);
            check_val("mem_wd", mem_wd, way_line(exp.way, exp.addr.index));
        end
        if (mem_re && !saw_re) begin
            saw_re = 1'b1;
            if (exp.kind == 2'd3 && !saw_we) complain("memory read came before the write-back");
            check_val("mem_addr", mem_addr, line_addr);
        end
        if (block_we != '0) check_val("block_we", block_we, way_mask_t'(1) << exp.way);
        if (wd_from_l1_en) begin
            saw_l1w = 1'b1;
            check_val("dirty_wd", dirty_wd, 1'b1);
        end
        if (wd_from_mem_en) begin
            saw_fill = 1'b1;
            check_val("dirty_wd", dirty_wd, 1'b0);
        end
        if (data_wd_l2_en) begin
            saw_rd = 1'b1;
            check_val("data_wd_l2", data_wd_l2, miss ? mem_word(line_addr, exp.addr.offset)
                                                     : way_word(exp.way, exp.addr.offset,
                                                                exp.addr.index));
            check_val("mem_wr_ic_en", mem_wr_ic_en, miss && exp_ic);
            check_val("mem_wr_dc_en", mem_wr_dc_en, miss && !exp_ic);
        end
    endtask

    task automatic finish_test();
        logic miss;
        miss = exp.kind[1];
        if (!miss && (saw_re || saw_we)) complain("memory was strobed on a hit");
        if (exp.kind == 2'd0 && !saw_rd) complain("no word went back to L1");
        if (exp.kind == 2'd1 && !saw_l1w) complain("hit way was never written");
        if (miss && !saw_re) complain("no memory read on a miss");
        if (miss && !saw_fill) complain("victim way was never refilled");
        if (exp.kind == 2'd2 && saw_we) complain("write-back on a clean miss");
        if (exp.kind == 2'd3 && !saw_we) complain("no write-back on a dirty miss");
        if (miss && exp.wr && !saw_l1w) complain("L1 line not written after refill");
        if (miss && !exp.wr && !saw_rd) complain("refill word never reached L1");
        tests++;
        if (errs != 0) failures++;
        $display("test %0d kind %0d %s: %s", tests, exp.kind, exp_ic ? "ic" : "dc",
                 (errs != 0) ? "failed" : "passed");
    endtask

    always @(posedge clk) begin
        if (rst) begin
            busy         = 1'b0;
            idle_flagged = 1'b0;
            tests        = 0;
            failures     = 0;
        end else if (!busy) begin
            if (ic_en || dc_en) begin
                busy     = 1'b1;
                errs     = 0;
                saw_re   = 1'b0;
                saw_we   = 1'b0;
                saw_fill = 1'b0;
                saw_l1w  = 1'b0;
                saw_rd   = 1'b0;
                check_val("ic_en", ic_en, exp_ic);    // priority order
                check_val("block_re", block_re, {NUM_WAYS{1'b1}});    // tag read of all ways
                check_val("index", index, exp.addr.index);
                check_val("offset", offset, exp.addr.offset);
                check_val("tag_wd", tag_wd, {1'b1, exp.addr.tag});
                sample();
            end else if ((block_re | block_we) != '0 || mem_re || mem_we || data_wd_l2_en ||
                         mem_wr_ic_en || mem_wr_dc_en || dirty_wd || wd_from_l1_en ||
                         wd_from_mem_en) begin
                if (!idle_flagged) begin
                    $display("outputs are active while no grant is held");
                    failures++;
                end
                idle_flagged = 1'b1;
            end
        end else if (!(ic_en || dc_en)) begin
            busy = 1'b0;
            finish_test();
        end else begin
            sample();
        end
    end

endmodule

// ==== tests/l2_ctrl_golden.txt ====
# src(0 ic,1 dc,2 both) wr addr tag0 tag1 tag2 tag3 (valid+tag) dirty plru
# kind(0 rd hit,1 wr hit,2 clean miss,3 dirty miss) way wb_addr
2 0 0091915 20456 20123 20123 00000 0 0 0 1 0000000
1 0 FFFFFFF 1ffff 20001 20002 3ffff 0 0 0 3 0000000
0 1 055E040 20001 20002 20abc 20abc 0 0 1 2 0000000
1 1 78782aa 2f0f0 2f0f0 00000 00000 f 0 1 0 0000000
0 0 0199C02 20001 20002 00333 20004 3 0 2 2 0000000
1 0 03BBB0D 20010 20011 20012 20013 e 0 2 0 0000000
0 0 91A2D54 20100 20200 20300 20400 2 2 3 1 0040155
1 1 5F7780F 2aaaa 2bbbb 2cccc 2dddd 8 5 3 3 1BBBA03
0 1 00211FD 21000 21001 21002 21003 3 1 2 2 0000000
1 0 002AE82 30000 30001 30002 30003 4 3 3 2 20005A0

// ==== tests/tb_l2_cache_ctrl.sv ====
`timescale 1ns/1ns
`include "l2_tb_defs.svh"

module tb_l2_cache_ctrl
    import l2_ctrl_pkg::*;
();

    logic      clk = 1'b0;
    logic      rst;
    l1_req_t   ic_req, dc_req;
    logic      l1_done, l2_complete_r, l2_complete_w, mem_complete_r, mem_complete_w;
    logic      ic_en, dc_en, data_wd_l2_en, mem_wr_ic_en, mem_wr_dc_en;
    word_t     data_wd_l2;
    index_t    index;
    offset_t   offset;
    tag_entry_t tag_wd;
    way_mask_t block_re, block_we;
    logic      dirty_wd, wd_from_l1_en, wd_from_mem_en, mem_re, mem_we;
    mem_addr_t mem_addr;
    line_t     mem_wd, mem_rd;
    line_t [NUM_WAYS-1:0] data_rd;
    tvec_t     cur;
    logic      exp_ic;
    tvec_t     vecs[$];
    int        seed = 32'h9cb9_b7de;
    int        limit = 0;
    int        n_trans = 0;
    int        tests, failures;

    always #4 clk = ~clk;

    // arrays and memory answer with the line patterns
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) data_rd[w] = way_line(w, cur.addr.index);
        mem_rd = mem_line(mem_addr);
    end

    l2_cache_ctrl u_l2_cache_ctrl (
        .clk(clk), .rst(rst), .ic_req(ic_req), .dc_req(dc_req), .l1_done(l1_done),
        .ic_en(ic_en), .dc_en(dc_en), .data_wd_l2(data_wd_l2),
        .data_wd_l2_en(data_wd_l2_en), .mem_wr_ic_en(mem_wr_ic_en),
        .mem_wr_dc_en(mem_wr_dc_en), .index(index), .offset(offset), .tag_wd(tag_wd),
        .block_re(block_re), .block_we(block_we), .dirty_wd(dirty_wd),
        .wd_from_l1_en(wd_from_l1_en), .wd_from_mem_en(wd_from_mem_en),
        .l2_complete_r(l2_complete_r), .l2_complete_w(l2_complete_w),
        .tag_rd(cur.tags), .data_rd(data_rd), .dirty_rd(cur.dirty), .plru(cur.plru),
        .mem_re(mem_re), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wd(mem_wd),
        .mem_rd(mem_rd), .mem_complete_r(mem_complete_r), .mem_complete_w(mem_complete_w)
    );

    l2_ctrl_checker u_checker (
        .clk(clk), .rst(rst), .exp(cur), .exp_ic(exp_ic), .ic_en(ic_en), .dc_en(dc_en),
        .data_wd_l2(data_wd_l2), .data_wd_l2_en(data_wd_l2_en),
        .mem_wr_ic_en(mem_wr_ic_en), .mem_wr_dc_en(mem_wr_dc_en),
        .index(index), .offset(offset), .tag_wd(tag_wd), .block_re(block_re),
        .block_we(block_we), .dirty_wd(dirty_wd), .wd_from_l1_en(wd_from_l1_en),
        .wd_from_mem_en(wd_from_mem_en), .mem_re(mem_re), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wd(mem_wd), .tests(tests), .failures(failures)
    );

    function automatic int pick_delay();
        pick_delay = 1 + ($unsigned($random(seed)) % 4);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // responders give one strobe each after a random wait
    //////////////////////////////////////////////////////////////////////

    always begin
        @(posedge clk);
        if (block_re != '0) begin
            repeat (pick_delay()) @(posedge clk);
            l2_complete_r <= 1'b1;
            @(posedge clk);
            l2_complete_r <= 1'b0;
        end
    end

    always begin
        @(posedge clk);
        if (block_we != '0) begin
            repeat (pick_delay()) @(posedge clk);
            l2_complete_w <= 1'b1;
            @(posedge clk);
            l2_complete_w <= 1'b0;
        end
    end

    always begin
        @(posedge clk);
        if (mem_re || mem_we) begin
            repeat (pick_delay()) @(posedge clk);
            if (mem_we) mem_complete_w <= 1'b1;
            else mem_complete_r <= 1'b1;
            @(posedge clk);
            mem_complete_w <= 1'b0;
            mem_complete_r <= 1'b0;
        end
    end

    always begin
        @(posedge clk);
        if (data_wd_l2_en) begin
            repeat (pick_delay()) @(posedge clk);
            if (data_wd_l2_en) begin
                l1_done <= 1'b1;
                @(posedge clk);
                l1_done <= 1'b0;
            end
        end
    end

    // waits for one grant, drops that request, waits for the grant to end
    task automatic serve_grant();
        do @(posedge clk); while (!(ic_en || dc_en));
        if (ic_en) ic_req <= '0;
        else dc_req <= '0;
        do @(posedge clk); while (ic_en || dc_en);
    endtask

    task automatic run_transaction(input tvec_t v);
        l1_req_t r;
        r = '{req: 1'b1, write: v.wr, addr: v.addr};
        @(posedge clk);
        cur    <= v;
        exp_ic <= (v.src != 2'd1);
        if (v.src != 2'd1) ic_req <= r;
        if (v.src != 2'd0) dc_req <= r;
        serve_grant();
        if (v.src == 2'd2) begin
            exp_ic <= 1'b0;    // data side follows
            serve_grant();
        end
    endtask

    task automatic load_vectors(input int fd);
        string line;
        logic [31:0] s, w, a, t0, t1, t2, t3, d, p, k, wy, wb;
        tvec_t v;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            s, w, a, t0, t1, t2, t3, d, p, k, wy, wb) == 12) begin
                    v = '{src: s[1:0], wr: w[0], addr: a[27:0],
                          tags: {t3[17:0], t2[17:0], t1[17:0], t0[17:0]},
                          dirty: d[3:0], plru: p[2:0], kind: k[1:0], way: wy[1:0],
                          wb: wb[25:0]};
                    vecs.push_back(v);
                    n_trans += (v.src == 2'd2) ? 2 : 1;
                end
            end
        end
    endtask

    initial begin
        int fd;
        rst = 1'b1;
        ic_req = '0;
        dc_req = '0;
        l1_done = 1'b0;
        l2_complete_r = 1'b0;
        l2_complete_w = 1'b0;
        mem_complete_r = 1'b0;
        mem_complete_w = 1'b0;
        cur = '0;
        exp_ic = 1'b1;
        fd = $fopen("tests/l2_ctrl_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            $display("TEST FAILED");
            $finish;
        end else begin
            load_vectors(fd);
            $fclose(fd);
            limit = n_trans * 60;
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            foreach (vecs[i]) run_transaction(vecs[i]);
            repeat (2) @(posedge clk);
            $display("tests %0d, failed %0d, expected %0d", tests, failures, n_trans);
            if (failures == 0 && tests == n_trans && n_trans > 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // watchdog sized from the transaction count
    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("watchdog expired before all transactions ended");
        $display("TEST FAILED");
        $finish;
    end

endmodule
